/* Makefile */
# Verilator build and run for the shared scratch memory testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mpa_top
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The log decides the outcome, so a missing pass line fails the target
run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* design/mpa_client_port.sv */
// Four-phase req/ack front end for one client; turns each handshake into one memory access
`timescale 1ns/1ps
`include "mpa_macros.svh"

module mpa_client_port (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cl_req,
  input  mpa_pkg::mpa_op_e  cl_op,
  input  mpa_pkg::addr_t    cl_addr,
  input  mpa_pkg::data_t    cl_wdata,
  output logic              cl_ack,
  output mpa_pkg::data_t    cl_rdata,
  mpa_req_if.client         bus
);
  import mpa_pkg::*;

  mpa_port_state_e state;
  mpa_port_state_e state_next;
  mpa_op_e         op_q;
  addr_t           addr_q;
  data_t           wdata_q;
  logic            start;
  logic            granted;
  logic            released;

  // Handshake events seen by the FSM
  assign start    = (state == ST_IDLE) && cl_req;
  assign granted  = (state == ST_WAIT_GNT) && bus.gnt;
  assign released = (state == ST_ACK) && !cl_req;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:     if (start) state_next = ST_WAIT_GNT;
      ST_WAIT_GNT: if (granted) state_next = ST_ACK;
      ST_ACK:      if (released) state_next = ST_IDLE;
      default:     state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Acknowledge rises the cycle after the grant edge
  // and stays up until the master drops cl_req
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cl_ack <= 1'b0;
    end else if (granted) begin
      cl_ack <= 1'b1;
    end else if (released) begin
      cl_ack <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------

  // The request is captured once so the shared side sees a steady payload
  always_ff @(posedge clk) begin
    if (start) begin
      op_q    <= cl_op;
      addr_q  <= cl_addr;
      wdata_q <= cl_wdata;
    end
  end

  // Memory returns read data combinationally in the grant cycle
  always_ff @(posedge clk) begin
    if (granted && op_q == OP_READ) begin
      cl_rdata <= bus.rdata;
    end
  end

  assign bus.req   = (state == ST_WAIT_GNT);
  assign bus.op    = op_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // The acknowledge flop and the FSM must agree
  a_ack_in_ack_state: assert property (@(posedge clk) disable iff (!rst_n)
    cl_ack |-> state == ST_ACK);

  // A new memory request only starts once the previous handshake is closed
  a_no_req_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bus.req) |-> !cl_ack);

endmodule

/* design/mpa_macros.svh */
// Size macros for the shared scratch memory; include wherever a width or count is needed
`ifndef MPA_MACROS_SVH
`define MPA_MACROS_SVH

// --------------------------------------------------
// Client and port counts
// --------------------------------------------------

// Number of peer clients sharing the memory
`define MPA_NUM_CLIENTS 4

// Number of memory access ports, between 2 and the client count
`define MPA_NUM_PORTS 2

// --------------------------------------------------
// Word geometry
// --------------------------------------------------

// Address width, so the array holds 2**MPA_ADDR_W words
`define MPA_ADDR_W 6

// Width of one data word
`define MPA_DATA_W 16

`endif

/* design/mpa_multi_rr_arb.sv */
// Round-robin arbiter granting up to one client per memory port each cycle, with a budget cap
`timescale 1ns/1ps
`include "mpa_macros.svh"

module mpa_multi_rr_arb (
  input  logic                                          clk,
  input  logic                                          rst_n,
  mpa_req_if.shared                                     reqs [`MPA_NUM_CLIENTS],
  input  mpa_pkg::budget_t                              budget,
  output mpa_pkg::client_vec_t [`MPA_NUM_PORTS-1:0]     grant_ordered
);
  import mpa_pkg::*;

  localparam int NC = `MPA_NUM_CLIENTS;
  localparam int NP = `MPA_NUM_PORTS;
  localparam int REQ_CNT_W = $clog2(NC + 1);

  client_vec_t                 req_vec;
  client_vec_t                 grant;
  client_vec_t [NP-1:0]        all_grants;
  client_vec_t                 lowest_prio;
  client_vec_t                 lowest_prio_next;
  logic [REQ_CNT_W-1:0]        req_count;
  budget_t                     eff_budget;
  budget_t                     grant_count;
  budget_t                     last_sel;
  logic [NP-1:0]               grant_valid;
  logic                        prio_update;

  // --------------------------------------------------
  // Interface fan-in and fan-out
  // --------------------------------------------------

  // Interface arrays need constant indices, so gather req and scatter gnt here
  for (genvar c = 0; c < NC; c++) begin : gen_if
    assign req_vec[c]  = reqs[c].req;
    assign reqs[c].gnt = grant[c];
  end

  // --------------------------------------------------
  // Candidate winners
  // --------------------------------------------------

  // Walk the clients once, starting just above the lowest-priority one
  // The first NP requesters found become the ordered candidates
  always_comb begin
    int lp_idx;
    int idx;
    int found;
    lp_idx     = 0;
    found      = 0;
    all_grants = '0;
    for (int i = 0; i < NC; i++) begin
      if (lowest_prio[i]) begin
        lp_idx = i;
      end
    end
    for (int k = 1; k <= NC; k++) begin
      idx = (lp_idx + k) % NC;
      if (req_vec[idx] && found < NP) begin
        all_grants[found][idx] = 1'b1;
        found++;
      end
    end
  end

  // --------------------------------------------------
  // Budget and grant count
  // --------------------------------------------------

  // A budget above the port count is treated as the port count
  assign eff_budget = (budget > budget_t'(NP)) ? budget_t'(NP) : budget;

  // Thermometer mask: ordered slot p may be used when the budget exceeds p
  for (genvar p = 0; p < NP; p++) begin : gen_valid
    assign grant_valid[p]   = eff_budget > budget_t'(p);
    assign grant_ordered[p] = grant_valid[p] ? all_grants[p] : '0;
  end

  always_comb begin
    req_count = '0;
    for (int i = 0; i < NC; i++) begin
      req_count += REQ_CNT_W'(req_vec[i]);
    end
  end

  // Grants issued this cycle are the smaller of requests and budget
  assign grant_count = (int'(req_count) <= int'(eff_budget)) ?
                       budget_t'(req_count) : eff_budget;

  // Flat grant view, one bit per client
  always_comb begin
    grant = '0;
    for (int p = 0; p < NP; p++) begin
      grant |= grant_ordered[p];
    end
  end

  // --------------------------------------------------
  // Priority pointer
  // --------------------------------------------------

  // The last granted client drops to the lowest priority
  assign last_sel    = (grant_count == '0) ? '0 : grant_count - 1'b1;
  assign prio_update = (grant_count != '0);

  always_comb begin
    lowest_prio_next = lowest_prio;
    for (int p = 0; p < NP; p++) begin
      if (int'(last_sel) == p) begin
        lowest_prio_next = all_grants[p];
      end
    end
  end

  // Reset value points at the top client so client 0 leads after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lowest_prio <= client_vec_t'(1) << (NC - 1);
    end else if (prio_update) begin
      lowest_prio <= lowest_prio_next;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // A client port sees gnt only while it holds req
  a_grant_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    (grant & ~req_vec) == '0);

  a_grant_within_budget: assert property (@(posedge clk) disable iff (!rst_n)
    $countones(grant) <= int'(budget));

  for (genvar p = 0; p < NP; p++) begin : gen_onehot_chk
    a_ordered_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(grant_ordered[p]));
  end

endmodule

/* design/mpa_pkg.sv */
// Shared types for the scratch memory design; import into any block that needs them
`include "mpa_macros.svh"

package mpa_pkg;

  // --------------------------------------------------
  // Enumerations
  // --------------------------------------------------

  // Access opcode carried with every request
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mpa_op_e;

  // Client port FSM states
  // ST_WAIT_GNT holds req until the arbiter answers
  // ST_ACK holds cl_ack until the master lets go
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_WAIT_GNT = 2'd1,
    ST_ACK      = 2'd2
  } mpa_port_state_e;

  // --------------------------------------------------
  // Sized data types
  // --------------------------------------------------

  // One memory address
  typedef logic [`MPA_ADDR_W-1:0] addr_t;

  // One data word
  typedef logic [`MPA_DATA_W-1:0] data_t;

  // One bit per client, bit i belongs to client i
  typedef logic [`MPA_NUM_CLIENTS-1:0] client_vec_t;

  // Grant budget, counts from zero up to the memory port count
  typedef logic [$clog2(`MPA_NUM_PORTS + 1)-1:0] budget_t;

endpackage

/* design/mpa_req_if.sv */
// Link between one client port and the shared arbiter and memory; one instance per client
`timescale 1ns/1ps
`include "mpa_macros.svh"

interface mpa_req_if;
  import mpa_pkg::*;

  // Request side, driven by the client port
  // The payload is held stable for as long as req is high
  logic    req;
  mpa_op_e op;
  addr_t   addr;
  data_t   wdata;

  // Grant comes from the arbiter in the same cycle as req
  logic    gnt;

  // Read data comes from the memory during the grant cycle
  data_t   rdata;

  // Client port view
  modport client (
    output req,
    output op,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  // Arbiter and memory view; the arbiter drives only gnt, the memory only rdata
  modport shared (
    input  req,
    input  op,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

/* design/mpa_shared_ram.sv */
// Multi-port scratch array; each port serves the client named by its ordered grant
`timescale 1ns/1ps
`include "mpa_macros.svh"

module mpa_shared_ram (
  input  logic                                      clk,
  mpa_req_if.shared                                 bus [`MPA_NUM_CLIENTS],
  input  mpa_pkg::client_vec_t [`MPA_NUM_PORTS-1:0] grant_ordered
);
  import mpa_pkg::*;

  localparam int NC        = `MPA_NUM_CLIENTS;
  localparam int NP        = `MPA_NUM_PORTS;
  localparam int MEM_DEPTH = 2 ** `MPA_ADDR_W;

  data_t         mem [MEM_DEPTH];

  mpa_op_e       client_op    [NC];
  addr_t         client_addr  [NC];
  data_t         client_wdata [NC];
  data_t         client_rdata [NC];

  logic [NP-1:0] port_busy;
  mpa_op_e       port_op    [NP];
  addr_t         port_addr  [NP];
  data_t         port_wdata [NP];
  data_t         port_rdata [NP];
  logic          port_clash;

  // --------------------------------------------------
  // Interface fan-in and fan-out
  // --------------------------------------------------

  for (genvar c = 0; c < NC; c++) begin : gen_if
    assign client_op[c]    = bus[c].op;
    assign client_addr[c]  = bus[c].addr;
    assign client_wdata[c] = bus[c].wdata;
    assign bus[c].rdata    = client_rdata[c];
  end

  // --------------------------------------------------
  // Port select
  // --------------------------------------------------

  // Each ordered grant is one-hot or zero, so at most one client matches a port
  // A port with no grant stays idle
  always_comb begin
    for (int p = 0; p < NP; p++) begin
      port_busy[p]  = |grant_ordered[p];
      port_op[p]    = OP_READ;
      port_addr[p]  = '0;
      port_wdata[p] = '0;
      for (int c = 0; c < NC; c++) begin
        if (grant_ordered[p][c]) begin
          port_op[p]    = client_op[c];
          port_addr[p]  = client_addr[c];
          port_wdata[p] = client_wdata[c];
        end
      end
    end
  end

  // --------------------------------------------------
  // Array access
  // --------------------------------------------------

  // Writes land at the edge that closes the grant cycle
  // Clients keep their writes in separate regions, so ports never collide
  always_ff @(posedge clk) begin
    for (int p = 0; p < NP; p++) begin
      if (port_busy[p] && port_op[p] == OP_WRITE) begin
        mem[port_addr[p]] <= port_wdata[p];
      end
    end
  end

  // Reads are combinational so the client port can latch at the grant edge
  for (genvar p = 0; p < NP; p++) begin : gen_rd
    assign port_rdata[p] = mem[port_addr[p]];
  end

  // Route each port's read word back to the client it serves
  always_comb begin
    for (int c = 0; c < NC; c++) begin
      client_rdata[c] = '0;
      for (int p = 0; p < NP; p++) begin
        if (grant_ordered[p][c]) begin
          client_rdata[c] = port_rdata[p];
        end
      end
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Flag any client that two ports try to serve at once
  always_comb begin
    port_clash = 1'b0;
    for (int p = 0; p < NP; p++) begin
      for (int q = p + 1; q < NP; q++) begin
        port_clash |= |(grant_ordered[p] & grant_ordered[q]);
      end
    end
  end

  a_no_double_select: assert property (@(posedge clk) !port_clash);

endmodule

/* design/mpa_top.sv */
// Top of the shared scratch memory; connect one four-phase master per client and a budget
`timescale 1ns/1ps
`include "mpa_macros.svh"

module mpa_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  mpa_pkg::budget_t                       budget,
  input  logic [`MPA_NUM_CLIENTS-1:0]            cl_req,
  output logic [`MPA_NUM_CLIENTS-1:0]            cl_ack,
  input  logic [`MPA_NUM_CLIENTS-1:0]            cl_op,
  input  mpa_pkg::addr_t [`MPA_NUM_CLIENTS-1:0]  cl_addr,
  input  mpa_pkg::data_t [`MPA_NUM_CLIENTS-1:0]  cl_wdata,
  output mpa_pkg::data_t [`MPA_NUM_CLIENTS-1:0]  cl_rdata
);
  import mpa_pkg::*;

  localparam int NC = `MPA_NUM_CLIENTS;
  localparam int NP = `MPA_NUM_PORTS;

  // Ordered grants, one client vector per memory port
  client_vec_t [NP-1:0] grant_ordered;

  // --------------------------------------------------
  // Client links
  // --------------------------------------------------

  // One link per client, shared by the arbiter and the memory
  mpa_req_if req_if [NC] ();

  // --------------------------------------------------
  // Client ports
  // --------------------------------------------------

  // The opcode arrives as a plain bit per client and is typed here
  for (genvar i = 0; i < NC; i++) begin : gen_port
    mpa_client_port i_port (
      .clk      (clk),
      .rst_n    (rst_n),
      .cl_req   (cl_req[i]),
      .cl_op    (mpa_op_e'(cl_op[i])),
      .cl_addr  (cl_addr[i]),
      .cl_wdata (cl_wdata[i]),
      .cl_ack   (cl_ack[i]),
      .cl_rdata (cl_rdata[i]),
      .bus      (req_if[i])
    );
  end

  // --------------------------------------------------
  // Arbiter and memory
  // --------------------------------------------------

  mpa_multi_rr_arb i_arb (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqs          (req_if),
    .budget        (budget),
    .grant_ordered (grant_ordered)
  );

  // Port p of the memory serves the p-th granted client
  mpa_shared_ram i_ram (
    .clk           (clk),
    .bus           (req_if),
    .grant_ordered (grant_ordered)
  );

endmodule

/* sim.f */
+incdir+design
design/mpa_pkg.sv
design/mpa_req_if.sv
design/mpa_multi_rr_arb.sv
design/mpa_client_port.sv
design/mpa_shared_ram.sv
design/mpa_top.sv
test/tb_clk_gen.sv
test/tb_mpa_top.sv

/* test/tb_clk_gen.sv */
// Testbench clock and reset source; instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset is released on a falling edge so no rising edge sees it change
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* test/tb_mpa_top.sv */
// Testbench top for the shared scratch memory; run with sim.f as the top module tb_mpa_top
`timescale 1ns/1ps
`include "mpa_macros.svh"

module tb_mpa_top;
  import mpa_pkg::*;

  localparam int NC             = `MPA_NUM_CLIENTS;
  localparam int NP             = `MPA_NUM_PORTS;
  localparam int MEM_DEPTH      = 2 ** `MPA_ADDR_W;
  localparam int REGION_W       = `MPA_ADDR_W - $clog2(NC);
  localparam int N_BASIC        = 8;
  localparam int N_RAND         = 75;
  localparam int N_FAIR         = 3;
  localparam int N_TOTAL        = 2 * N_BASIC + MEM_DEPTH + NC * (N_RAND + N_FAIR + 1);
  localparam int TIMEOUT_CYCLES = N_TOTAL * 10 * NC;

  // What each client worker does with its transactions
  localparam int MODE_FILL   = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_WRITE  = 2;

  logic           clk;
  logic           rst_n;
  budget_t        budget;
  client_vec_t    cl_req;
  client_vec_t    cl_ack;
  client_vec_t    cl_op;
  addr_t [NC-1:0] cl_addr;
  data_t [NC-1:0] cl_wdata;
  data_t [NC-1:0] cl_rdata;

  // Shadow copy of the memory, the reference model
  data_t          shadow [MEM_DEPTH];
  addr_t          basic_addr [N_BASIC];
  integer         seed;
  int             n_pass;
  int             n_err;
  int             done_cnt;

  // Monitor state, written only by the monitor below
  client_vec_t    prev_ack    = '0;
  client_vec_t    prev_req    = '0;
  int             model_lp    = NC - 1;
  int             proto_err   = 0;
  int             stall_rises = 0;
  int             cycles      = 0;
  client_vec_t    ack_log [$];
  bit             stall_on;
  bit             fair_on;

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mpa_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .budget   (budget),
    .cl_req   (cl_req),
    .cl_ack   (cl_ack),
    .cl_op    (cl_op),
    .cl_addr  (cl_addr),
    .cl_wdata (cl_wdata),
    .cl_rdata (cl_rdata)
  );

  // --------------------------------------------------
  // Compare tasks and helpers
  // --------------------------------------------------

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      n_err++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_client(input string name, input client_vec_t got,
                              input client_vec_t exp);
    if (got !== exp) begin
      n_err++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end else begin
      n_pass++;
    end
  endtask

  // Top address bits name the client, so regions never overlap
  function automatic addr_t region_addr(input int c, input int off);
    return addr_t'((c << REGION_W) | (off & ((1 << REGION_W) - 1)));
  endfunction

  function automatic data_t fill_word(input addr_t a);
    return data_t'({~a, a});
  endfunction

  // Four-phase master for one client
  // The model is updated on a write acknowledge and compared on a read acknowledge
  task automatic access(input int c, input mpa_op_e op, input addr_t addr, input data_t wdata);
    @(negedge clk);
    cl_op[c]    = op;
    cl_addr[c]  = addr;
    cl_wdata[c] = wdata;
    cl_req[c]   = 1'b1;
    @(negedge clk);
    while (!cl_ack[c]) @(negedge clk);
    if (op == OP_WRITE) begin
      shadow[addr] = wdata;
    end else begin
      check_data($sformatf("cl_rdata[%0d]", c), cl_rdata[c], shadow[addr]);
    end
    cl_req[c] = 1'b0;
    @(negedge clk);
    while (cl_ack[c]) @(negedge clk);
  endtask

  task automatic worker(input int c, input int mode, input int count);
    mpa_op_e op;
    addr_t   addr;
    data_t   wdata;
    for (int i = 0; i < count; i++) begin
      case (mode)
        MODE_FILL: begin
          op    = OP_WRITE;
          addr  = region_addr(c, i);
          wdata = fill_word(addr);
        end
        MODE_RANDOM: begin
          op    = ($random(seed) & 1) ? OP_WRITE : OP_READ;
          addr  = region_addr(c, $random(seed));
          wdata = data_t'($random(seed));
        end
        default: begin
          op    = OP_WRITE;
          addr  = region_addr(c, i);
          wdata = data_t'($random(seed));
        end
      endcase
      access(c, op, addr, wdata);
    end
    done_cnt++;
  endtask

  // Start one worker per client; the caller waits on done_cnt
  task automatic launch_all(input int mode, input int count);
    done_cnt = 0;
    for (int c = 0; c < NC; c++) begin
      automatic int cc = c;
      fork
        worker(cc, mode, count);
      join_none
    end
  endtask

  task automatic report_test(input string name, input int errs);
    $display("%s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  // --------------------------------------------------
  // Handshake monitor and pointer model
  // --------------------------------------------------

  // Sampled at the rising edge, so every value seen is from the cycle just ended
  always @(posedge clk) begin
    client_vec_t rise;
    client_vec_t fall;
    int          idx;
    int          nlp;
    rise = cl_ack & ~prev_ack;
    fall = prev_ack & ~cl_ack;
    nlp  = model_lp;
    if (rst_n) begin
      for (int c = 0; c < NC; c++) begin
        if (rise[c] && !prev_req[c]) begin
          proto_err++;
          $display("Client %0d raised its acknowledge without a request", c);
        end
        if (fall[c] && prev_req[c]) begin
          proto_err++;
          $display("Client %0d dropped its acknowledge while the request was high", c);
        end
      end
      if (stall_on && rise != '0) stall_rises++;
      if (fair_on && rise != '0) ack_log.push_back(rise);
      // The last client granted, in round-robin order, becomes the lowest priority
      for (int k = 1; k <= NC; k++) begin
        idx = (model_lp + k) % NC;
        if (rise[idx]) nlp = idx;
      end
    end
    model_lp = nlp;
    prev_ack = cl_ack;
    prev_req = cl_req;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    client_vec_t exp_vec;
    int          lp;
    int          nxt;
    int          idx;
    int          errs;
    int          reset_errs;
    int          fair_left [NC];
    seed     = 32'h9e22c062;
    budget   = budget_t'(NP);
    cl_req   = '0;
    cl_op    = '0;
    cl_addr  = '0;
    cl_wdata = '0;
    n_pass   = 0;
    n_err    = 0;
    done_cnt = 0;
    stall_on = 1'b0;
    fair_on  = 1'b0;

    repeat (4) @(negedge clk);
    check_client("cl_ack", cl_ack, '0);
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_client("cl_ack", cl_ack, '0);
    reset_errs = n_err;

    // Single client writes, then reads the same words back
    errs = n_err;
    for (int i = 0; i < N_BASIC; i++) begin
      basic_addr[i] = region_addr(0, $random(seed));
      access(0, OP_WRITE, basic_addr[i], data_t'($random(seed)));
    end
    for (int i = 0; i < N_BASIC; i++) begin
      access(0, OP_READ, basic_addr[i], '0);
    end
    report_test("write then read back", n_err - errs);

    // Fill every region first so each random read has a known word
    errs = n_err;
    launch_all(MODE_FILL, MEM_DEPTH / NC);
    wait (done_cnt == NC);
    launch_all(MODE_RANDOM, N_RAND);
    wait (done_cnt == NC);
    report_test("random concurrent traffic", n_err - errs);

    // One grant per cycle with every client busy
    errs    = n_err;
    budget  = budget_t'(1);
    lp      = model_lp;
    fair_on = 1'b1;
    launch_all(MODE_RANDOM, N_FAIR);
    wait (done_cnt == NC);
    fair_on = 1'b0;
    budget  = budget_t'(NP);
    if (ack_log.size() != NC * N_FAIR) begin
      n_err++;
      $display("Fairness run saw %0d acknowledges for %0d transactions",
               ack_log.size(), NC * N_FAIR);
    end
    for (int c = 0; c < NC; c++) begin
      fair_left[c] = N_FAIR;
    end
    foreach (ack_log[i]) begin
      // Next winner is the first client above the pointer that still has work
      nxt = lp;
      for (int k = NC; k >= 1; k--) begin
        idx = (lp + k) % NC;
        if (fair_left[idx] > 0) nxt = idx;
      end
      exp_vec = client_vec_t'(1) << nxt;
      check_client("cl_ack order", ack_log[i], exp_vec);
      fair_left[nxt]--;
      lp = nxt;
    end
    report_test("round-robin under budget 1", n_err - errs);

    // Requests wait with a zero budget, then all drain
    errs     = n_err;
    budget   = '0;
    stall_on = 1'b1;
    launch_all(MODE_WRITE, 1);
    repeat (20) @(negedge clk);
    check_client("cl_ack", cl_ack, '0);
    stall_on = 1'b0;
    budget   = budget_t'(NP);
    wait (done_cnt == NC);
    if (stall_rises != 0) begin
      n_err++;
      $display("An acknowledge rose %0d times while the budget was zero", stall_rises);
    end
    report_test("budget zero stall", n_err - errs);

    report_test("handshake protocol", proto_err + reset_errs);

    $display("Checks passed: %0d, errors: %0d", n_pass, n_err + proto_err);
    if (n_err + proto_err == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
